// File: filelist.f
hw/cache_pkg.sv
hw/data_store.sv
hw/tag_store.sv
hw/lru_tracker.sv
hw/cache_ctrl.sv
hw/cache_top.sv
sim/mem_model.sv
sim/cache_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS = --lint-only --timing -Wall --timescale 1ns/1ps
TOP       = cache_tb
RTL_TOP   = cache_top
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/cache_tb.sv
/*
 * Testbench for the blocking data cache. Runs directed hit, miss, merge,
 * write-back and LRU scenarios against a word-level reference of memory.
 */
module cache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_WAYS           = 4;
    localparam int LINE_WORDS         = 4;
    localparam int MAX_REQUESTS       = 200;
    localparam int CYCLES_PER_REQUEST = 40;

    logic        clk;
    logic        rst_n;
    logic        cpu_req_valid;
    logic        cpu_req_we;
    logic [31:0] cpu_req_addr;
    logic [31:0] cpu_req_wdata;
    logic [3:0]  cpu_req_wstrb;
    logic        cpu_stall;
    logic        cpu_resp_valid;
    logic [31:0] cpu_resp_rdata;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        mem_resp_valid;

    // CPU-visible memory contents, keyed by word address
    logic [31:0] ref_mem [logic [29:0]];

    // Memory requests of the current CPU access
    logic        log_we    [$];
    logic [31:0] log_addr  [$];
    logic [31:0] log_wdata [$];

    logic [31:0] rdata;
    int          latency;

    cache_top #(.NUM_WAYS(NUM_WAYS)) cache_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_we     (cpu_req_we),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_req_wdata  (cpu_req_wdata),
        .cpu_req_wstrb  (cpu_req_wstrb),
        .cpu_stall      (cpu_stall),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp_rdata (cpu_resp_rdata),
        .mem_req        (mem_req),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata),
        .mem_resp_valid (mem_resp_valid)
    );

    mem_model mem_model_inst (
        .clk            (clk),
        .mem_req        (mem_req),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata),
        .mem_resp_valid (mem_resp_valid)
    );

    // ====================
    // Helpers
    // ====================

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            stop_with_error($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    function automatic logic [31:0] initial_word(input logic [29:0] wa);
        return {2'b00, wa} ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        if (ref_mem.exists(addr[31:2])) begin
            return ref_mem[addr[31:2]];
        end
        return initial_word(addr[31:2]);
    endfunction

    // Starts at 2 ns after an edge with the cache idle, ends the same way
    task cpu_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                    input logic [3:0] wstrb);
        cpu_req_valid = 1'b1;
        cpu_req_we    = we;
        cpu_req_addr  = addr;
        cpu_req_wdata = wdata;
        cpu_req_wstrb = wstrb;
        @(posedge clk);
        #2;
        cpu_req_valid = 1'b0;
        cpu_req_we    = 1'b0;
        log_we.delete();
        log_addr.delete();
        log_wdata.delete();
        check_value("cpu_stall", 32'(cpu_stall), 32'h1);
        latency = 1;
        while (!cpu_resp_valid) begin
            @(posedge clk);
            #2;
            latency++;
        end
        rdata = cpu_resp_rdata;
        @(posedge clk);
        #2;
    endtask

    task read_and_check(input logic [31:0] addr);
        cpu_access(1'b0, addr, 32'h0, 4'h0);
        check_value("cpu_resp_rdata", rdata, expected_word(addr));
    endtask

    task write_merge(input logic [31:0] addr, input logic [31:0] wdata,
                     input logic [3:0] wstrb);
        logic [31:0] merged;
        merged = expected_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                merged[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        ref_mem[addr[31:2]] = merged;
        cpu_access(1'b1, addr, wdata, wstrb);
        check_value("cpu_resp_rdata", rdata, 32'h0);
    endtask

    task automatic mem_request_count(input int expected);
        check_value("mem_req count", 32'(log_addr.size()), 32'(expected));
    endtask

    task automatic verify_hit();
        mem_request_count(0);
        check_value("hit latency", 32'(latency), 32'd3);
    endtask

    task automatic expect_refill(input logic [31:0] addr, input int first);
        logic [31:0] base;
        base = addr & ~32'hF;
        for (int i = 0; i < LINE_WORDS; i++) begin
            check_value("mem_we", 32'(log_we[first+i]), 32'h0);
            check_value("mem_addr", log_addr[first+i], base + 32'(4 * i));
        end
    endtask

    task automatic expect_writeback(input logic [31:0] victim);
        logic [31:0] base;
        base = victim & ~32'hF;
        for (int i = 0; i < LINE_WORDS; i++) begin
            check_value("mem_we", 32'(log_we[i]), 32'h1);
            check_value("mem_addr", log_addr[i], base + 32'(4 * i));
            check_value("mem_wdata", log_wdata[i], expected_word(base + 32'(4 * i)));
        end
    endtask

    // ====================
    // Clock, monitor, watchdog
    // ====================

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        if (mem_req) begin
            log_we.push_back(mem_we);
            log_addr.push_back(mem_addr);
            log_wdata.push_back(mem_wdata);
        end
    end

    initial begin
        repeat (MAX_REQUESTS * CYCLES_PER_REQUEST) @(posedge clk);
        stop_with_error("Timeout: the cache stopped answering requests");
    end

    // ====================
    // Stimulus
    // ====================

    initial begin
        rst_n         = 1'b0;
        cpu_req_valid = 1'b0;
        cpu_req_we    = 1'b0;
        cpu_req_addr  = '0;
        cpu_req_wdata = '0;
        cpu_req_wstrb = '0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        repeat (3) begin
            check_value("cpu_stall", 32'(cpu_stall), 32'h0);
            check_value("cpu_resp_valid", 32'(cpu_resp_valid), 32'h0);
            check_value("mem_req", 32'(mem_req), 32'h0);
            @(posedge clk);
            #2;
        end

        // Read miss, then hits on the same line
        read_and_check(32'h0000_0104);
        mem_request_count(LINE_WORDS);
        expect_refill(32'h0000_0104, 0);
        read_and_check(32'h0000_0104);
        verify_hit();
        read_and_check(32'h0000_010C);
        verify_hit();

        // Strobed write hit and write miss
        write_merge(32'h0000_0104, 32'hDEAD_BEEF, 4'b0101);
        verify_hit();
        read_and_check(32'h0000_0104);
        verify_hit();
        write_merge(32'h0000_0208, 32'h1234_5678, 4'b1010);
        mem_request_count(LINE_WORDS);
        expect_refill(32'h0000_0208, 0);
        read_and_check(32'h0000_0208);
        verify_hit();

        // Set 3: dirty A is the LRU victim when E comes in
        write_merge(32'h0000_1034, 32'hCAFE_F00D, 4'b1111);
        mem_request_count(LINE_WORDS);
        read_and_check(32'h0000_2030);
        read_and_check(32'h0000_3038);
        read_and_check(32'h0000_403C);
        mem_request_count(LINE_WORDS);
        read_and_check(32'h0000_5030);
        mem_request_count(2 * LINE_WORDS);
        expect_writeback(32'h0000_1034);
        expect_refill(32'h0000_5030, LINE_WORDS);
        read_and_check(32'h0000_1034);
        mem_request_count(LINE_WORDS);
        expect_refill(32'h0000_1034, 0);

        // Set 5: re-read A so that B becomes the victim
        read_and_check(32'h0000_1050);
        read_and_check(32'h0000_2054);
        read_and_check(32'h0000_3058);
        read_and_check(32'h0000_405C);
        read_and_check(32'h0000_1050);
        verify_hit();
        read_and_check(32'h0000_5050);
        mem_request_count(LINE_WORDS);
        expect_refill(32'h0000_5050, 0);
        read_and_check(32'h0000_1050);
        verify_hit();
        read_and_check(32'h0000_2054);
        mem_request_count(LINE_WORDS);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: sim/mem_model.sv
/*
 * Behavioral word memory for the cache testbench. Answers each memory
 * request after 1 to 4 cycles; unwritten words read as a fixed pattern.
 */
module mem_model (
    input  logic        clk,
    input  logic        mem_req,
    input  logic        mem_we,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    output logic [31:0] mem_rdata,
    output logic        mem_resp_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] words [logic [29:0]];
    integer      seed;
    int          delay;
    logic [29:0] word_addr;

    // Word address folded into the upper half
    function automatic logic [31:0] pattern_word(input logic [29:0] wa);
        return {2'b00, wa} ^ 32'hA5A5_0000;
    endfunction

    initial begin
        seed           = 13453;
        mem_rdata      = '0;
        mem_resp_valid = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (mem_req) begin
                word_addr = mem_addr[31:2];
                delay     = 1 + (($random(seed) & 32'h7FFF_FFFF) % 4);
                if (mem_we) begin
                    words[word_addr] = mem_wdata;
                end
                repeat (delay) @(posedge clk);
                #2;
                mem_rdata      = words.exists(word_addr) ? words[word_addr]
                                                         : pattern_word(word_addr);
                mem_resp_valid = 1'b1;
                @(posedge clk);
                #2;
                mem_resp_valid = 1'b0;
            end
        end
    end

endmodule

// File: hw/cache_top.sv
/*
 * Blocking write-back data cache. Connects the controller FSM to the
 * tag, data and LRU storage. NUM_WAYS sets the associativity.
 */
module cache_top #(
    parameter int NUM_WAYS = 4
) (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        cpu_req_valid,
    input  logic        cpu_req_we,
    input  logic [31:0] cpu_req_addr,
    input  logic [31:0] cpu_req_wdata,
    input  logic [3:0]  cpu_req_wstrb,
    output logic        cpu_stall,
    output logic        cpu_resp_valid,
    output logic [31:0] cpu_resp_rdata,

    output logic        mem_req,
    output logic        mem_we,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    input  logic [31:0] mem_rdata,
    input  logic        mem_resp_valid
);
    import cache_pkg::*;

    localparam int WAY_BITS = $clog2(NUM_WAYS);

    logic [INDEX_BITS-1:0]    lookup_index;
    logic [TAG_BITS-1:0]      lookup_tag;
    logic                     hit;
    logic [WAY_BITS-1:0]      hit_way;
    logic [WAY_BITS-1:0]      victim_way;
    logic [TAG_BITS-1:0]      victim_tag;
    logic                     victim_dirty;
    logic                     fill_en;
    logic [WAY_BITS-1:0]      fill_way;
    logic [TAG_BITS-1:0]      fill_tag;
    logic                     fill_dirty;
    logic                     mark_dirty_en;
    logic [WAY_BITS-1:0]      mark_dirty_way;
    logic [WAY_BITS-1:0]      data_way;
    logic [WORD_SEL_BITS-1:0] data_word;
    logic                     data_we;
    logic [31:0]              data_wdata;
    logic [31:0]              data_rdata;
    logic                     lru_touch;
    logic [WAY_BITS-1:0]      lru_touch_way;
    logic [WAY_BITS-1:0]      lru_way;

    cache_ctrl #(.NUM_WAYS(NUM_WAYS)) ctrl_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_we     (cpu_req_we),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_req_wdata  (cpu_req_wdata),
        .cpu_req_wstrb  (cpu_req_wstrb),
        .cpu_stall      (cpu_stall),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp_rdata (cpu_resp_rdata),
        .mem_req        (mem_req),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata),
        .mem_resp_valid (mem_resp_valid),
        .lookup_index   (lookup_index),
        .lookup_tag     (lookup_tag),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .victim_tag     (victim_tag),
        .victim_dirty   (victim_dirty),
        .fill_en        (fill_en),
        .fill_way       (fill_way),
        .fill_tag       (fill_tag),
        .fill_dirty     (fill_dirty),
        .mark_dirty_en  (mark_dirty_en),
        .mark_dirty_way (mark_dirty_way),
        .data_way       (data_way),
        .data_word      (data_word),
        .data_we        (data_we),
        .data_wdata     (data_wdata),
        .data_rdata     (data_rdata),
        .lru_touch      (lru_touch),
        .lru_touch_way  (lru_touch_way)
    );

    tag_store #(.NUM_WAYS(NUM_WAYS)) tag_store_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup_index   (lookup_index),
        .lookup_tag     (lookup_tag),
        .lru_way        (lru_way),
        .fill_en        (fill_en),
        .fill_way       (fill_way),
        .fill_tag       (fill_tag),
        .fill_dirty     (fill_dirty),
        .mark_dirty_en  (mark_dirty_en),
        .mark_dirty_way (mark_dirty_way),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .victim_tag     (victim_tag),
        .victim_dirty   (victim_dirty)
    );

    data_store #(.NUM_WAYS(NUM_WAYS)) data_store_inst (
        .clk   (clk),
        .index (lookup_index),
        .way   (data_way),
        .word  (data_word),
        .we    (data_we),
        .wdata (data_wdata),
        .rdata (data_rdata)
    );

    lru_tracker #(.NUM_WAYS(NUM_WAYS)) lru_tracker_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .index     (lookup_index),
        .touch     (lru_touch),
        .touch_way (lru_touch_way),
        .lru_way   (lru_way)
    );

endmodule

// File: hw/cache_ctrl.sv
/*
 * Cache controller FSM. Serves one CPU request at a time: lookup, optional
 * write-back of a dirty victim, line refill, then a one-cycle response.
 */
module cache_ctrl #(
    parameter int NUM_WAYS = 4,
    localparam int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  logic                               clk,
    input  logic                               rst_n,

    input  logic                               cpu_req_valid,
    input  logic                               cpu_req_we,
    input  logic [31:0]                        cpu_req_addr,
    input  logic [31:0]                        cpu_req_wdata,
    input  logic [3:0]                         cpu_req_wstrb,
    output logic                               cpu_stall,
    output logic                               cpu_resp_valid,
    output logic [31:0]                        cpu_resp_rdata,

    output logic                               mem_req,
    output logic                               mem_we,
    output logic [31:0]                        mem_addr,
    output logic [31:0]                        mem_wdata,
    input  logic [31:0]                        mem_rdata,
    input  logic                               mem_resp_valid,

    output logic [cache_pkg::INDEX_BITS-1:0]   lookup_index,
    output logic [cache_pkg::TAG_BITS-1:0]     lookup_tag,
    input  logic                               hit,
    input  logic [WAY_BITS-1:0]                hit_way,
    input  logic [WAY_BITS-1:0]                victim_way,
    input  logic [cache_pkg::TAG_BITS-1:0]     victim_tag,
    input  logic                               victim_dirty,
    output logic                               fill_en,
    output logic [WAY_BITS-1:0]                fill_way,
    output logic [cache_pkg::TAG_BITS-1:0]     fill_tag,
    output logic                               fill_dirty,
    output logic                               mark_dirty_en,
    output logic [WAY_BITS-1:0]                mark_dirty_way,

    output logic [WAY_BITS-1:0]                data_way,
    output logic [cache_pkg::WORD_SEL_BITS-1:0] data_word,
    output logic                               data_we,
    output logic [31:0]                        data_wdata,
    input  logic [31:0]                        data_rdata,

    output logic                               lru_touch,
    output logic [WAY_BITS-1:0]                lru_touch_way
);
    import cache_pkg::*;

    ctrl_state_e              state;
    cache_addr_u              req_addr;
    cache_addr_u              burst_addr;
    logic                     req_we;
    logic [31:0]              req_wdata;
    logic [3:0]               req_wstrb;
    logic [WAY_BITS-1:0]      way_q;
    logic [TAG_BITS-1:0]      victim_tag_q;
    logic [WORD_SEL_BITS-1:0] beat;
    logic                     last_beat;
    logic                     accept;
    logic [31:0]              strb_mask;
    logic [31:0]              merged_word;

    // ====================
    // Datapath
    // ====================

    assign accept    = cpu_req_valid && !cpu_stall;
    assign cpu_stall = (state != ST_IDLE) || cpu_resp_valid;
    assign last_beat = (beat == WORD_SEL_BITS'(WORDS_PER_LINE - 1));

    assign lookup_index = req_addr.f.index;
    assign lookup_tag   = req_addr.f.tag;

    assign strb_mask   = {{8{req_wstrb[3]}}, {8{req_wstrb[2]}},
                          {8{req_wstrb[1]}}, {8{req_wstrb[0]}}};
    assign merged_word = (data_rdata & ~strb_mask) | (req_wdata & strb_mask);

    // Tag written with the last refill word
    assign fill_en    = (state == ST_REFILL_WAIT) && mem_resp_valid && last_beat;
    assign fill_way   = way_q;
    assign fill_tag   = req_addr.f.tag;
    assign fill_dirty = req_we;

    assign mark_dirty_en  = (state == ST_RESPOND) && req_we;
    assign mark_dirty_way = way_q;

    assign lru_touch     = ((state == ST_LOOKUP) && hit) || fill_en;
    assign lru_touch_way = (state == ST_LOOKUP) ? hit_way : way_q;

    assign data_way   = way_q;
    assign data_word  = (state == ST_RESPOND) ? req_addr.f.word : beat;
    assign data_we    = ((state == ST_REFILL_WAIT) && mem_resp_valid) || mark_dirty_en;
    assign data_wdata = (state == ST_RESPOND) ? merged_word : mem_rdata;

    // Victim line base during write-back, request line base otherwise
    always_comb begin
        burst_addr = req_addr;
        if (state == ST_WB_REQ) begin
            burst_addr.f.tag = victim_tag_q;
        end
        burst_addr.f.word     = beat;
        burst_addr.f.byte_off = '0;
    end

    // ====================
    // FSM
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ST_IDLE;
            beat           <= '0;
            mem_req        <= 1'b0;
            mem_we         <= 1'b0;
            cpu_resp_valid <= 1'b0;
        end else begin
            mem_req        <= 1'b0;
            cpu_resp_valid <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_LOOKUP;
                    end
                end

                ST_LOOKUP: begin
                    state <= hit ? ST_RESPOND : ST_MISS_SELECT;
                end

                ST_MISS_SELECT: begin
                    beat  <= '0;
                    state <= victim_dirty ? ST_WB_REQ : ST_REFILL_REQ;
                end

                ST_WB_REQ: begin
                    mem_req <= 1'b1;
                    mem_we  <= 1'b1;
                    state   <= ST_WB_WAIT;
                end

                ST_WB_WAIT: begin
                    if (mem_resp_valid) begin
                        beat  <= last_beat ? '0 : beat + 1'b1;
                        state <= last_beat ? ST_REFILL_REQ : ST_WB_REQ;
                    end
                end

                ST_REFILL_REQ: begin
                    mem_req <= 1'b1;
                    mem_we  <= 1'b0;
                    state   <= ST_REFILL_WAIT;
                end

                ST_REFILL_WAIT: begin
                    if (mem_resp_valid) begin
                        beat  <= last_beat ? '0 : beat + 1'b1;
                        state <= last_beat ? ST_RESPOND : ST_REFILL_REQ;
                    end
                end

                ST_RESPOND: begin
                    cpu_resp_valid <= 1'b1;
                    state          <= ST_IDLE;
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request, victim and bus payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr.raw <= cpu_req_addr;
            req_we       <= cpu_req_we;
            req_wdata    <= cpu_req_wdata;
            req_wstrb    <= cpu_req_wstrb;
        end
        if ((state == ST_LOOKUP) && hit) begin
            way_q <= hit_way;
        end
        if (state == ST_MISS_SELECT) begin
            way_q        <= victim_way;
            victim_tag_q <= victim_tag;
        end
        if ((state == ST_WB_REQ) || (state == ST_REFILL_REQ)) begin
            mem_addr <= burst_addr.raw;
        end
        if (state == ST_WB_REQ) begin
            mem_wdata <= data_rdata;
        end
        if (state == ST_RESPOND) begin
            cpu_resp_rdata <= req_we ? '0 : data_rdata;
        end
    end

endmodule

// File: hw/lru_tracker.sv
/*
 * True LRU per set kept as an age per way, 0 being the youngest.
 * A touch makes the way youngest and reports the oldest way of the set.
 */
module lru_tracker #(
    parameter int NUM_WAYS = 4,
    localparam int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [cache_pkg::INDEX_BITS-1:0] index,
    input  logic                             touch,
    input  logic [WAY_BITS-1:0]              touch_way,
    output logic [WAY_BITS-1:0]              lru_way
);
    import cache_pkg::*;

    logic [WAY_BITS-1:0] age [NUM_SETS][NUM_WAYS];

    // Ages form a permutation, so exactly one way is the oldest
    always_comb begin
        lru_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (age[index][w] == WAY_BITS'(NUM_WAYS - 1)) begin
                lru_way = WAY_BITS'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Way 0 starts as the oldest
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    age[s][w] <= WAY_BITS'(NUM_WAYS - 1 - w);
                end
            end
        end else if (touch) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (WAY_BITS'(w) == touch_way) begin
                    age[index][w] <= '0;
                end else if (age[index][w] < age[index][touch_way]) begin
                    age[index][w] <= age[index][w] + 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/tag_store.sv
/*
 * Tag, valid and dirty arrays. Combinational hit compare and victim choice
 * for the looked-up set, single-cycle fill and mark-dirty writes.
 */
module tag_store #(
    parameter int NUM_WAYS = 4,
    localparam int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [cache_pkg::INDEX_BITS-1:0] lookup_index,
    input  logic [cache_pkg::TAG_BITS-1:0]   lookup_tag,
    input  logic [WAY_BITS-1:0]              lru_way,
    input  logic                             fill_en,
    input  logic [WAY_BITS-1:0]              fill_way,
    input  logic [cache_pkg::TAG_BITS-1:0]   fill_tag,
    input  logic                             fill_dirty,
    input  logic                             mark_dirty_en,
    input  logic [WAY_BITS-1:0]              mark_dirty_way,
    output logic                             hit,
    output logic [WAY_BITS-1:0]              hit_way,
    output logic [WAY_BITS-1:0]              victim_way,
    output logic [cache_pkg::TAG_BITS-1:0]   victim_tag,
    output logic                             victim_dirty
);
    import cache_pkg::*;

    logic [TAG_BITS-1:0] tag_mem [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_q [NUM_SETS];

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[lookup_index][w] && (tag_mem[lookup_index][w] == lookup_tag)) begin
                hit     = 1'b1;
                hit_way = WAY_BITS'(w);
            end
        end
    end

    // Lowest invalid way wins over the LRU way
    always_comb begin
        victim_way = lru_way;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[lookup_index][w]) begin
                victim_way = WAY_BITS'(w);
            end
        end
        victim_tag   = tag_mem[lookup_index][victim_way];
        victim_dirty = valid_q[lookup_index][victim_way] && dirty_q[lookup_index][victim_way];
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[lookup_index][fill_way] <= fill_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            if (fill_en) begin
                valid_q[lookup_index][fill_way] <= 1'b1;
                dirty_q[lookup_index][fill_way] <= fill_dirty;
            end
            if (mark_dirty_en) begin
                dirty_q[lookup_index][mark_dirty_way] <= 1'b1;
            end
        end
    end

endmodule

// File: hw/data_store.sv
/*
 * Cache data array, one 32-bit word per entry across all sets, ways
 * and line words. Asynchronous read, write on the clock edge.
 */
module data_store #(
    parameter int NUM_WAYS = 4,
    localparam int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  logic                                clk,
    input  logic [cache_pkg::INDEX_BITS-1:0]    index,
    input  logic [WAY_BITS-1:0]                 way,
    input  logic [cache_pkg::WORD_SEL_BITS-1:0] word,
    input  logic                                we,
    input  logic [31:0]                         wdata,
    output logic [31:0]                         rdata
);
    import cache_pkg::*;

    localparam int DEPTH     = NUM_SETS * NUM_WAYS * WORDS_PER_LINE;
    localparam int ADDR_BITS = INDEX_BITS + WAY_BITS + WORD_SEL_BITS;

    logic [31:0]          mem [DEPTH];
    logic [ADDR_BITS-1:0] addr;

    // Set, then way, then word
    assign addr  = {index, way, word};
    assign rdata = mem[addr];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

endmodule

// File: hw/cache_pkg.sv
/*
 * Shared cache geometry, address layout and controller state encoding.
 * Imported by every RTL block of the data cache.
 */
package cache_pkg;

    localparam int BYTE_BITS      = 2;
    localparam int WORD_SEL_BITS  = 2;
    localparam int WORDS_PER_LINE = 1 << WORD_SEL_BITS;
    localparam int INDEX_BITS     = 4;
    localparam int NUM_SETS       = 1 << INDEX_BITS;
    localparam int TAG_BITS       = 32 - INDEX_BITS - WORD_SEL_BITS - BYTE_BITS;

    // Field view of a byte address
    typedef struct packed {
        logic [TAG_BITS-1:0]      tag;
        logic [INDEX_BITS-1:0]    index;
        logic [WORD_SEL_BITS-1:0] word;
        logic [BYTE_BITS-1:0]     byte_off;
    } cache_addr_fields_s;

    // Raw word for the memory bus, fields for the arrays
    typedef union packed {
        logic [31:0]        raw;
        cache_addr_fields_s f;
    } cache_addr_u;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MISS_SELECT,
        ST_WB_REQ,
        ST_WB_WAIT,
        ST_REFILL_REQ,
        ST_REFILL_WAIT,
        ST_RESPOND
    } ctrl_state_e;

endpackage
